// ==== riscv_memwb_consts.svh ====
// RV32 only; RV_ACKQ_DEPTH must be at least 2 and bounds the data-memory requests in flight
`ifndef RISCV_MEMWB_CONSTS_SVH
`define RISCV_MEMWB_CONSTS_SVH

////////////////////////////////////////
// Datapath
////////////////////////////////////////

// Data and address width
`define RV_XLEN 32

// Register-number width
`define RV_REG_BITS 5

////////////////////////////////////////
// Pipeline shape
////////////////////////////////////////

`define RV_MEM_STAGES 2  // Default memory stages between issue and write-back

// Ack queue entries, also the cap on outstanding requests
`define RV_ACKQ_DEPTH 4

`endif

// ==== riscv_memwb_pkg.sv ====
// Item fields take their widths from the constants header, opcode set limited to ALU, LW, LBU and SW
`include "riscv_memwb_consts.svh"

package riscv_memwb_pkg;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_ALU = 2'b00,  // Register write of the ALU result
    OP_LW  = 2'b01,
    OP_LBU = 2'b10,  // Zero-extended byte load
    OP_SW  = 2'b11   // No register write
  } mem_op_e;

  // Data bus access size
  typedef enum logic [1:0] {
    BYTE  = 2'b00,
    HWORD = 2'b01,
    WORD  = 2'b10
  } biu_size_e;

  typedef enum logic [1:0] {
    EXC_NONE          = 2'b00,
    EXC_LD_MISALIGNED = 2'b01,
    EXC_ST_MISALIGNED = 2'b10
  } exc_cause_e;

  ////////////////////////////////////////
  // Pipeline item
  ////////////////////////////////////////

  typedef struct packed {
    logic                    bubble;  // Empty slot
    mem_op_e                 op;
    logic [`RV_REG_BITS-1:0] dst;
    logic [`RV_XLEN-1:0]     r;       // ALU result or memory address
    logic [`RV_XLEN-1:0]     d;       // Store data
    exc_cause_e              exc;
  } mem_item_t;

endpackage

// ==== riscv_lsu_issue.sv ====
// Word accesses must be 4-byte aligned and an item is taken only while ex_stall_o is low
`timescale 1ns/10ps
`include "riscv_memwb_consts.svh"

module riscv_lsu_issue
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       ex_valid_i,
  input  riscv_memwb_pkg::mem_op_e   ex_op_i,
  input  logic [`RV_REG_BITS-1:0]    ex_dst_i,
  input  logic [`RV_XLEN-1:0]        ex_r_i,
  input  logic [`RV_XLEN-1:0]        ex_d_i,
  input  logic                       mem_stall_i,
  input  logic                       mem_retire_i,
  output logic                       ex_stall_o,
  output riscv_memwb_pkg::mem_item_t item_o,
  output logic                       dmem_req_o,
  output logic                       dmem_we_o,
  output logic [`RV_XLEN-1:0]        dmem_adr_o,
  output logic [`RV_XLEN-1:0]        dmem_d_o,
  output riscv_memwb_pkg::biu_size_e dmem_size_o
);
  import riscv_memwb_pkg::*;

  localparam int CNT_BITS = $clog2(`RV_ACKQ_DEPTH + 1);

  mem_item_t           item_q;
  exc_cause_e          exc;
  logic                misaligned;
  logic                hold;
  logic                accept;
  logic                issue_req;
  logic                req_q;
  logic [CNT_BITS-1:0] cnt_q;  // Requests in flight

  assign misaligned = |ex_r_i[1:0];

  always_comb
  begin
    case (ex_op_i)
      OP_LW:   exc = misaligned ? EXC_LD_MISALIGNED : EXC_NONE;
      OP_SW:   exc = misaligned ? EXC_ST_MISALIGNED : EXC_NONE;
      default: exc = EXC_NONE;  // LBU has no alignment rule
    endcase
  end

  ////////////////////////////////////////
  // Stall and accept
  ////////////////////////////////////////

  assign hold       = mem_stall_i & ~item_q.bubble;
  assign ex_stall_o = hold | (cnt_q == CNT_BITS'(`RV_ACKQ_DEPTH));
  assign accept     = ex_valid_i & ~ex_stall_o;
  assign issue_req  = accept & (ex_op_i != OP_ALU) & (exc == EXC_NONE);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      item_q.bubble <= 1'b1;
      req_q         <= 1'b0;
    end
    else
    begin
      req_q <= issue_req;  // One-cycle pulse
      if (!hold)
      begin
        item_q <= '{bubble: ~accept, op: ex_op_i, dst: ex_dst_i,
                    r: ex_r_i, d: ex_d_i, exc: exc};
      end
    end
  end

  // Outstanding count, retire comes back from write-back
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      cnt_q <= '0;
    else
      cnt_q <= cnt_q + CNT_BITS'(issue_req) - CNT_BITS'(mem_retire_i);
  end

  assign item_o      = item_q;
  assign dmem_req_o  = req_q;
  assign dmem_adr_o  = item_q.r;
  assign dmem_d_o    = item_q.d;
  assign dmem_we_o   = (item_q.op == OP_SW);
  assign dmem_size_o = (item_q.op == OP_LBU) ? BYTE : WORD;

endmodule

// ==== riscv_mem_stage.sv ====
// Holds a valid item while stalled from below and lets a bubble be overwritten
`timescale 1ns/10ps

module riscv_mem_stage
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  riscv_memwb_pkg::mem_item_t item_i,
  input  logic                       stall_i,   // From the next stage
  output riscv_memwb_pkg::mem_item_t item_o,
  output logic                       stall_o    // To the previous stage
);
  import riscv_memwb_pkg::*;

  mem_item_t item_q;

  // Only a real item blocks the stage above
  assign stall_o = stall_i & ~item_q.bubble;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      item_q.bubble <= 1'b1;
    end
    else if (!stall_o)
    begin
      item_q <= item_i;
    end
  end

  assign item_o = item_q;

endmodule

// ==== riscv_wb.sv ====
// Acks must arrive in request order, one per request, and never more than RV_ACKQ_DEPTH ahead
`timescale 1ns/10ps
`include "riscv_memwb_consts.svh"

module riscv_wb
(
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  riscv_memwb_pkg::mem_item_t  item_i,
  input  logic                        dmem_ack_i,
  input  logic [`RV_XLEN-1:0]         dmem_q_i,
  output logic                        stall_o,
  output logic                        mem_retire_o,
  output logic                        wb_valid_o,
  output logic                        wb_we_o,
  output logic [`RV_REG_BITS-1:0]     wb_dst_o,
  output logic [`RV_XLEN-1:0]         wb_r_o,
  output riscv_memwb_pkg::exc_cause_e wb_exc_o,
  output logic [`RV_XLEN-1:0]         wb_badaddr_o
);
  import riscv_memwb_pkg::*;

  localparam int DEPTH    = `RV_ACKQ_DEPTH;
  localparam int PTR_BITS = $clog2(DEPTH);
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  logic [`RV_XLEN-1:0]  ackq [DEPTH];
  logic [PTR_BITS-1:0]  wr_ptr_q;
  logic [PTR_BITS-1:0]  rd_ptr_q;
  logic [CNT_BITS-1:0]  fill_q;
  logic [`RV_XLEN-1:0]  head;
  logic [7:0]           load_byte;
  logic [`RV_XLEN-1:0]  result;
  logic                 needs_ack;
  logic                 retire;
  logic                 pop;

  function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] p);
    return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  ////////////////////////////////////////
  // Retire control
  ////////////////////////////////////////

  // Clean loads and stores made a request and wait for its ack
  assign needs_ack    = ~item_i.bubble & (item_i.op != OP_ALU) & (item_i.exc == EXC_NONE);
  assign stall_o      = needs_ack & (fill_q == '0);
  assign retire       = ~item_i.bubble & ~stall_o;
  assign pop          = retire & needs_ack;
  assign mem_retire_o = pop;

  ////////////////////////////////////////
  // Ack queue
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (dmem_ack_i)
      ackq[wr_ptr_q] <= dmem_q_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end
    else
    begin
      if (dmem_ack_i)
        wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop)
        rd_ptr_q <= next_ptr(rd_ptr_q);
      fill_q <= fill_q + CNT_BITS'(dmem_ack_i) - CNT_BITS'(pop);
    end
  end

  assign head      = ackq[rd_ptr_q];
  assign load_byte = head[{item_i.r[1:0], 3'b000} +: 8];  // Byte lane from address

  always_comb
  begin
    case (item_i.op)
      OP_LW:   result = head;
      OP_LBU:  result = {{(`RV_XLEN-8){1'b0}}, load_byte};
      default: result = item_i.r;
    endcase
  end

  ////////////////////////////////////////
  // Write-back register
  ////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wb_valid_o <= 1'b0;
      wb_we_o    <= 1'b0;
      wb_exc_o   <= EXC_NONE;
    end
    else
    begin
      wb_valid_o <= retire;
      wb_we_o    <= retire & (item_i.op != OP_SW) & (item_i.exc == EXC_NONE);
      wb_exc_o   <= retire ? item_i.exc : EXC_NONE;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (retire)
    begin
      wb_dst_o     <= item_i.dst;
      wb_r_o       <= result;
      wb_badaddr_o <= (item_i.exc == EXC_NONE) ? '0 : item_i.r;  // Faulting address
    end
  end

endmodule

// ==== riscv_memwb.sv ====
// MEM_STAGES must be at least 1 and each dmem request gets exactly one in-order ack
`timescale 1ns/10ps
`include "riscv_memwb_consts.svh"

module riscv_memwb #(
  parameter int MEM_STAGES = `RV_MEM_STAGES
)
(
  input  logic                        clk_i,
  input  logic                        rst_i,

  // Execute side
  input  logic                        ex_valid_i,
  input  riscv_memwb_pkg::mem_op_e    ex_op_i,
  input  logic [`RV_REG_BITS-1:0]     ex_dst_i,
  input  logic [`RV_XLEN-1:0]         ex_r_i,
  input  logic [`RV_XLEN-1:0]         ex_d_i,
  output logic                        ex_stall_o,

  // Data memory bus
  output logic                        dmem_req_o,
  output logic                        dmem_we_o,
  output logic [`RV_XLEN-1:0]         dmem_adr_o,
  output logic [`RV_XLEN-1:0]         dmem_d_o,
  output riscv_memwb_pkg::biu_size_e  dmem_size_o,
  input  logic                        dmem_ack_i,
  input  logic [`RV_XLEN-1:0]         dmem_q_i,

  // Register file write and exception report
  output logic                        wb_valid_o,
  output logic                        wb_we_o,
  output logic [`RV_REG_BITS-1:0]     wb_dst_o,
  output logic [`RV_XLEN-1:0]         wb_r_o,
  output riscv_memwb_pkg::exc_cause_e wb_exc_o,
  output logic [`RV_XLEN-1:0]         wb_badaddr_o
);
  import riscv_memwb_pkg::*;

  mem_item_t pipe_item  [MEM_STAGES+1];  // Items travel down
  logic      pipe_stall [MEM_STAGES+1];  // Stalls travel up
  logic      mem_retire;

  riscv_lsu_issue issue0 (
    .clk_i        ( clk_i         ),
    .rst_i        ( rst_i         ),
    .ex_valid_i   ( ex_valid_i    ),
    .ex_op_i      ( ex_op_i       ),
    .ex_dst_i     ( ex_dst_i      ),
    .ex_r_i       ( ex_r_i        ),
    .ex_d_i       ( ex_d_i        ),
    .mem_stall_i  ( pipe_stall[0] ),
    .mem_retire_i ( mem_retire    ),
    .ex_stall_o   ( ex_stall_o    ),
    .item_o       ( pipe_item[0]  ),
    .dmem_req_o   ( dmem_req_o    ),
    .dmem_we_o    ( dmem_we_o     ),
    .dmem_adr_o   ( dmem_adr_o    ),
    .dmem_d_o     ( dmem_d_o      ),
    .dmem_size_o  ( dmem_size_o   ) );

  genvar n;
  generate
    for (n = 0; n < MEM_STAGES; n++)
    begin : g_mem
      riscv_mem_stage stage (
        .clk_i   ( clk_i           ),
        .rst_i   ( rst_i           ),
        .item_i  ( pipe_item [n]   ),
        .stall_i ( pipe_stall[n+1] ),
        .item_o  ( pipe_item [n+1] ),
        .stall_o ( pipe_stall[n]   ) );
    end
  endgenerate

  riscv_wb wb0 (
    .clk_i        ( clk_i                  ),
    .rst_i        ( rst_i                  ),
    .item_i       ( pipe_item [MEM_STAGES] ),
    .dmem_ack_i   ( dmem_ack_i             ),
    .dmem_q_i     ( dmem_q_i               ),
    .stall_o      ( pipe_stall[MEM_STAGES] ),
    .mem_retire_o ( mem_retire             ),
    .wb_valid_o   ( wb_valid_o             ),
    .wb_we_o      ( wb_we_o                ),
    .wb_dst_o     ( wb_dst_o               ),
    .wb_r_o       ( wb_r_o                 ),
    .wb_exc_o     ( wb_exc_o               ),
    .wb_badaddr_o ( wb_badaddr_o           ) );

endmodule

// ==== tb_clkgen.sv ====
// Free-running 10 ns clock, reset held high through the first 3 rising edges
`timescale 1ns/10ps

module tb_clkgen
(
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial
  begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    rst_o <= 1'b0;  // Released on the rising edge
  end

endmodule

// ==== tb_riscv_memwb_chk.sv ====
// Bound into riscv_memwb and reads its internal retire strobe, so the top level must keep that name
`timescale 1ns/10ps
`include "riscv_memwb_consts.svh"

module tb_riscv_memwb_chk
(
  input logic                        clk_i,
  input logic                        rst_i,
  input logic                        ex_valid_i,
  input logic                        ex_stall_i,
  input logic                        dmem_req_i,
  input logic [`RV_XLEN-1:0]         dmem_adr_i,
  input riscv_memwb_pkg::biu_size_e  dmem_size_i,
  input logic                        mem_retire_i,
  input logic                        wb_valid_i,
  input logic                        wb_we_i,
  input riscv_memwb_pkg::exc_cause_e wb_exc_i
);
  import riscv_memwb_pkg::*;

  int unsigned fails = 0;
  int unsigned in_flight;  // Requests not yet retired

  always @(posedge clk_i)
  begin
    if (rst_i)
      in_flight <= 0;
    else
      in_flight <= in_flight + dmem_req_i - mem_retire_i;
  end

  ////////////////////////////////////////
  // Properties
  ////////////////////////////////////////

  // Pipe comes out of reset empty and quiet
  a_reset_quiet: assert property (@(posedge clk_i)
    $fell(rst_i) |-> !wb_valid_i && !dmem_req_i && !ex_stall_i)
    else
    begin
      $error("outputs active right after reset");
      fails++;
    end

  a_in_flight: assert property (@(posedge clk_i) disable iff (rst_i)
    in_flight <= `RV_ACKQ_DEPTH)
    else
    begin
      $error("more requests in flight than the ack queue holds");
      fails++;
    end

  a_aligned_req: assert property (@(posedge clk_i) disable iff (rst_i)
    dmem_req_i && dmem_size_i == WORD |-> dmem_adr_i[1:0] == 2'b00)
    else
    begin
      $error("word request sent to a misaligned address");
      fails++;
    end

  // A stalled item must not reach the bus
  a_stall_blocks: assert property (@(posedge clk_i) disable iff (rst_i)
    ex_valid_i && ex_stall_i |=> !dmem_req_i)
    else
    begin
      $error("request issued for an item offered during a stall");
      fails++;
    end

  a_exc_no_write: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_valid_i && wb_exc_i != EXC_NONE |-> !wb_we_i)
    else
    begin
      $error("register write together with an exception");
      fails++;
    end

endmodule

bind riscv_memwb tb_riscv_memwb_chk chk0 (
  .clk_i        ( clk_i       ),
  .rst_i        ( rst_i       ),
  .ex_valid_i   ( ex_valid_i  ),
  .ex_stall_i   ( ex_stall_o  ),
  .dmem_req_i   ( dmem_req_o  ),
  .dmem_adr_i   ( dmem_adr_o  ),
  .dmem_size_i  ( dmem_size_o ),
  .mem_retire_i ( mem_retire  ),
  .wb_valid_i   ( wb_valid_o  ),
  .wb_we_i      ( wb_we_o     ),
  .wb_exc_i     ( wb_exc_o    ) );

// ==== tb_riscv_memwb.sv ====
// Five memory stages let a stream fill the ack queue; memory answers in order after 1 to 4 cycles
`timescale 1ns/10ps
`include "riscv_memwb_consts.svh"

module tb_riscv_memwb;
  import riscv_memwb_pkg::*;

  localparam int MEM_STAGES = `RV_ACKQ_DEPTH + 1;  // More stages than ack queue entries
  localparam int N_ITEMS    = 1 + 7 + 3 + 40;  // Items over all tests
  localparam int TIMEOUT    = N_ITEMS * (MEM_STAGES + 2 + 4) + 100;
  localparam logic [31:0] FILL = 32'h5a3c_96e1;  // Background memory pattern

  typedef struct packed {
    logic        we;
    logic [4:0]  dst;
    logic [31:0] r;
    exc_cause_e  exc;
    logic [31:0] badaddr;
  } wb_exp_t;

  logic        clk_i;
  logic        rst_i;
  logic        ex_valid_i;
  mem_op_e     ex_op_i;
  logic [4:0]  ex_dst_i;
  logic [31:0] ex_r_i;
  logic [31:0] ex_d_i;
  logic        ex_stall_o;
  logic        dmem_req_o;
  logic        dmem_we_o;
  logic [31:0] dmem_adr_o;
  logic [31:0] dmem_d_o;
  biu_size_e   dmem_size_o;
  logic        dmem_ack_i;
  logic [31:0] dmem_q_i;
  logic        wb_valid_o;
  logic        wb_we_o;
  logic [4:0]  wb_dst_o;
  logic [31:0] wb_r_o;
  exc_cause_e  wb_exc_o;
  logic [31:0] wb_badaddr_o;

  wb_exp_t     exp_q [$];
  biu_size_e   size_q [$];  // Bus size of each request still to come
  wb_exp_t     seen;
  logic [31:0] ref_words [logic [29:0]];  // What the pipe should read back
  logic [31:0] mem_words [logic [29:0]];  // Memory model contents
  int          due_q [$];
  logic [31:0] data_q [$];
  logic [31:0] word;
  logic [31:0] stim_seed = 32'd83;
  logic [31:0] mem_seed  = 32'd83;
  int          checks = 0;
  int          errors = 0;
  int          tests = 0;
  int          req_cnt = 0;
  int          mcyc = 0;
  int          due;
  int          last_due = 0;
  int          run_cycles = 0;

  tb_clkgen clkgen0 (.clk_o(clk_i), .rst_o(rst_i));

  riscv_memwb #(.MEM_STAGES(MEM_STAGES)) dut0 (.*);

  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1103515245 + 32'd12345;
    return state;
  endfunction

  function automatic logic [31:0] background_word(input logic [31:0] adr);
    return {adr[31:2], 2'b00} ^ FILL;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("Error %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  // Expected write-back of one accepted item
  function automatic wb_exp_t expect_item(input mem_op_e op, input logic [4:0] dst,
                                          input logic [31:0] r, input logic [31:0] d);
    wb_exp_t     e;
    logic [31:0] w;
    w = ref_words.exists(r[31:2]) ? ref_words[r[31:2]] : background_word(r);
    e = '{we: 1'b1, dst: dst, r: r, exc: EXC_NONE, badaddr: r};
    if ((op == OP_LW || op == OP_SW) && r[1:0] != 2'b00)
    begin
      e.we  = 1'b0;
      e.exc = (op == OP_LW) ? EXC_LD_MISALIGNED : EXC_ST_MISALIGNED;
    end
    else if (op == OP_LW)
      e.r = w;
    else if (op == OP_LBU)
      e.r = (w >> (8 * r[1:0])) & 32'hff;
    else if (op == OP_SW)
    begin
      e.we = 1'b0;
      ref_words[r[31:2]] = d;
    end
    return e;
  endfunction

  // Called on a rising edge, returns on the edge that takes the item
  task automatic send_item(input mem_op_e op, input logic [4:0] dst,
                           input logic [31:0] r, input logic [31:0] d);
    logic    stalled;
    wb_exp_t e;
    ex_valid_i <= 1'b1;
    ex_op_i    <= op;
    ex_dst_i   <= dst;
    ex_r_i     <= r;
    ex_d_i     <= d;
    do
    begin
      @(negedge clk_i);
      stalled = ex_stall_o;
      @(posedge clk_i);
    end
    while (stalled);
    e = expect_item(op, dst, r, d);
    exp_q.push_back(e);
    if (op != OP_ALU && e.exc == EXC_NONE)
      size_q.push_back((op == OP_LBU) ? BYTE : WORD);  // Byte loads use a byte access
  endtask

  task automatic drain();
    ex_valid_i <= 1'b0;
    while (exp_q.size() != 0)
      @(posedge clk_i);
  endtask

  task automatic end_test(input string name, input int c0, input int e0);
    tests++;
    $display("Test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
  endtask

  ////////////////////////////////////////
  // Memory model and monitors
  ////////////////////////////////////////

  always @(posedge clk_i)
  begin
    if (rst_i)
      dmem_ack_i <= 1'b0;
    else
    begin
      if (dmem_req_o)
      begin
        req_cnt++;
        if (size_q.size() == 0)
        begin
          $display("Data-memory request seen with no clean load or store accepted");
          errors++;
        end
        else
          check_value("dmem_size_o", dmem_size_o, size_q.pop_front());
        word = mem_words.exists(dmem_adr_o[31:2]) ? mem_words[dmem_adr_o[31:2]]
                                                  : background_word(dmem_adr_o);
        if (dmem_we_o)
          mem_words[dmem_adr_o[31:2]] = dmem_d_o;
        due = mcyc + 1 + int'((lcg_next(mem_seed) >> 16) % 4);
        if (due <= last_due)
          due = last_due + 1;  // Keep acks in order
        last_due = due;
        due_q.push_back(due);
        data_q.push_back(word);
      end
      if (due_q.size() != 0 && due_q[0] == mcyc)
      begin
        dmem_ack_i <= 1'b1;
        dmem_q_i   <= data_q.pop_front();
        void'(due_q.pop_front());
      end
      else
        dmem_ack_i <= 1'b0;
    end
    mcyc++;
  end

  always @(negedge clk_i)
  begin
    if (!rst_i && wb_valid_o)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Write-back seen with no item accepted");
        errors++;
      end
      else
      begin
        seen = exp_q.pop_front();
        check_value("wb_we_o", wb_we_o, seen.we);
        check_value("wb_exc_o", wb_exc_o, seen.exc);
        if (seen.we)
        begin
          check_value("wb_dst_o", wb_dst_o, seen.dst);
          check_value("wb_r_o", wb_r_o, seen.r);
        end
        if (seen.exc != EXC_NONE)
          check_value("wb_badaddr_o", wb_badaddr_o, seen.badaddr);
      end
    end
  end

  always @(posedge clk_i)
  begin
    run_cycles++;
    if (run_cycles > TIMEOUT)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  initial
  begin
    int          c0;
    int          e0;
    int          lat;
    int          n_req;
    logic [31:0] rnd;
    logic [31:0] adr;
    mem_op_e     op;
    ex_valid_i = 1'b0;
    ex_op_i    = OP_ALU;
    ex_dst_i   = '0;
    ex_r_i     = '0;
    ex_d_i     = '0;
    dmem_ack_i = 1'b0;
    dmem_q_i   = '0;

    @(posedge clk_i);
    while (rst_i)
      @(posedge clk_i);
    c0 = checks;
    e0 = errors;
    repeat (3)
    begin
      @(negedge clk_i);
      check_value("wb_valid_o", wb_valid_o, 0);
      check_value("dmem_req_o", dmem_req_o, 0);
      check_value("ex_stall_o", ex_stall_o, 0);
    end
    @(posedge clk_i);
    end_test("reset", c0, e0);

    // Latency counted from the edge that presents the item
    c0 = checks;
    e0 = errors;
    send_item(OP_ALU, 5'd7, 32'h1234_5678, 32'h0);
    ex_valid_i <= 1'b0;
    lat = 1;
    @(negedge clk_i);
    while (!wb_valid_o && lat < 20)
    begin
      @(posedge clk_i);
      lat++;
      @(negedge clk_i);
    end
    check_value("ALU latency", lat, MEM_STAGES + 2);
    @(posedge clk_i);
    drain();
    end_test("alu", c0, e0);

    c0 = checks;
    e0 = errors;
    send_item(OP_LW, 5'd1, 32'h0000_0100, 32'h0);
    send_item(OP_LBU, 5'd2, 32'h0000_0101, 32'h0);
    send_item(OP_LBU, 5'd3, 32'h0000_0103, 32'h0);
    send_item(OP_SW, 5'd4, 32'h0000_0200, 32'hcafe_1234);
    send_item(OP_LW, 5'd5, 32'h0000_0200, 32'h0);
    send_item(OP_LBU, 5'd6, 32'h0000_0202, 32'h0);
    send_item(OP_SW, 5'd8, 32'h0000_0204, 32'h0bad_f00d);
    drain();
    end_test("load_store", c0, e0);

    c0 = checks;
    e0 = errors;
    n_req = req_cnt;
    send_item(OP_LW, 5'd9, 32'h0000_0301, 32'h0);
    send_item(OP_SW, 5'd10, 32'h0000_0302, 32'h1111_2222);
    send_item(OP_LW, 5'd11, 32'h0000_0303, 32'h0);
    drain();
    check_value("dmem_req_o count", req_cnt - n_req, 0);
    end_test("misaligned", c0, e0);

    // Back-to-back stream over a 128 byte window
    c0 = checks;
    e0 = errors;
    repeat (40)
    begin
      rnd = lcg_next(stim_seed);
      op  = mem_op_e'(rnd[17:16]);
      adr = {25'h0, rnd[22:18], rnd[27:26]};
      if (op != OP_LBU && rnd[25:23] != 3'd0)
        adr[1:0] = 2'b00;  // Mostly aligned
      send_item(op, rnd[15:11], (op == OP_ALU) ? rnd : adr, {rnd[15:0], rnd[31:16]});
    end
    drain();
    end_test("random", c0, e0);

    $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, checks, errors, dut0.chk0.fails);
    if (errors == 0 && dut0.chk0.fails == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
riscv_memwb_pkg.sv
riscv_lsu_issue.sv
riscv_mem_stage.sv
riscv_wb.sv
riscv_memwb.sv
tb_clkgen.sv
tb_riscv_memwb_chk.sv
tb_riscv_memwb.sv
